/* source/muldiv_pkg.sv */
/* arithmetic types shared by the multiply and divide units
   operand pair, result word views, opcode and iteration constants */

`default_nettype none

package muldiv_pkg;

  // ------------------------------------------------------------
  // iteration constants
  // ------------------------------------------------------------

  // one shift step per operand bit
  localparam int iter_count = 32;
  // wide enough to count down from iter_count - 1
  localparam int count_width = 5;

  // ------------------------------------------------------------
  // operation and operand types
  // ------------------------------------------------------------

  typedef enum logic {
    op_mul = 1'b0,
    op_div = 1'b1
  } muldiv_op_e;

  // both operands are signed 32-bit words
  typedef struct packed {
    logic signed [31:0] a;
    logic signed [31:0] b;
  } operands_t;

  // divide result with remainder in the upper word
  typedef struct packed {
    logic [31:0] remainder;
    logic [31:0] quotient;
  } divres_t;

  // one 64-bit result word seen as a product or as a divide pair
  typedef union packed {
    logic [63:0] product;
    divres_t     divres;
  } muldiv_result_u;

endpackage

`default_nettype wire

/* source/muldiv_regs_pkg.sv */
/* AXI4-Lite channel structs and the register map of the accelerator
   offsets, response codes and control and status bit positions */

`default_nettype none

package muldiv_regs_pkg;

  // ------------------------------------------------------------
  // AXI4-Lite channels
  // ------------------------------------------------------------

  // driven by the master
  typedef struct packed {
    logic        awvalid;
    logic [7:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [7:0]  araddr;
    logic        rready;
  } axil_req_t;

  // driven by the slave
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

  // ------------------------------------------------------------
  // register map
  // ------------------------------------------------------------

  localparam logic [7:0] reg_opa    = 8'h00;
  localparam logic [7:0] reg_opb    = 8'h04;
  localparam logic [7:0] reg_ctrl   = 8'h08;
  localparam logic [7:0] reg_status = 8'h0C;
  localparam logic [7:0] reg_res_lo = 8'h10;
  localparam logic [7:0] reg_res_hi = 8'h14;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  localparam int ctrl_start_bit = 0;
  localparam int ctrl_op_bit    = 1;
  localparam int stat_busy_bit  = 0;
  localparam int stat_done_bit  = 1;

endpackage

`default_nettype wire

/* source/int_mul_iterative.sv */
/* iterative signed shift-add multiplier
   idle/calc/done FSM, magnitude datapath and output sign fix */

`timescale 1ns/1ps
`default_nettype none

module int_mul_iterative (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_val,
  output logic                       req_rdy,
  input  muldiv_pkg::operands_t      operands,
  output logic                       resp_val,
  input  logic                       resp_rdy,
  output muldiv_pkg::muldiv_result_u result
);

  typedef enum logic [1:0] {st_idle, st_calc, st_done} state_e;

  state_e state;

  // multiplicand moves left, multiplier moves right
  logic [63:0] mcand;
  logic [31:0] mplier;
  logic [63:0] acc;
  logic [muldiv_pkg::count_width-1:0] count;
  logic neg;

  logic [31:0] mag_a;
  logic [31:0] mag_b;
  logic req_fire;
  logic resp_fire;

  assign req_rdy   = (state == st_idle);
  assign resp_val  = (state == st_done);
  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;

  // operand magnitudes, most negative value maps to 2^31
  assign mag_a = operands.a[31] ? (~operands.a + 32'd1) : operands.a;
  assign mag_b = operands.b[31] ? (~operands.b + 32'd1) : operands.b;

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (req_fire) begin
            state <= st_calc;
          end
        end
        // last step runs with the counter at zero
        st_calc: begin
          if (count == '0) begin
            state <= st_done;
          end
        end
        st_done: begin
          if (resp_fire) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_fire) begin
      mcand  <= {32'd0, mag_a};
      mplier <= mag_b;
      acc    <= '0;
      count  <= (muldiv_pkg::count_width)'(muldiv_pkg::iter_count - 1);
      neg    <= operands.a[31] ^ operands.b[31];
    end else if (state == st_calc) begin
      // add the partial product for this multiplier bit
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
      count  <= count - 1'b1;
    end
  end

  // product sign restored on the way out
  always_comb begin
    result.product = neg ? (~acc + 64'd1) : acc;
  end

  // fixed latency from accept to response
  assert property (@(posedge clk) disable iff (reset)
    req_fire |=> (!req_rdy) [*muldiv_pkg::iter_count] ##1 resp_val);

  // response held until taken
  assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(result));

endmodule

`default_nettype wire

/* source/int_div_iterative.sv */
/* iterative signed restoring divider
   idle/calc/done FSM, magnitude datapath, sign fix and divide-by-zero */

`timescale 1ns/1ps
`default_nettype none

module int_div_iterative (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_val,
  output logic                       req_rdy,
  input  muldiv_pkg::operands_t      operands,
  output logic                       resp_val,
  input  logic                       resp_rdy,
  output muldiv_pkg::muldiv_result_u result
);

  typedef enum logic [1:0] {st_idle, st_calc, st_done} state_e;

  state_e state;

  // dividend bits leave at the top while quotient bits enter at the bottom
  logic [31:0] dvd;
  logic [31:0] dvsr;
  logic [31:0] rem;
  logic [muldiv_pkg::count_width-1:0] count;
  logic q_neg;
  logic r_neg;
  logic dvz;

  logic [31:0] mag_a;
  logic [31:0] mag_b;
  logic [32:0] rem_shift;
  logic [32:0] trial;
  logic req_fire;
  logic resp_fire;

  assign req_rdy   = (state == st_idle);
  assign resp_val  = (state == st_done);
  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;

  assign mag_a = operands.a[31] ? (~operands.a + 32'd1) : operands.a;
  assign mag_b = operands.b[31] ? (~operands.b + 32'd1) : operands.b;

  // partial remainder with next dividend bit, then the trial subtract
  assign rem_shift = {rem, dvd[31]};
  assign trial     = rem_shift - {1'b0, dvsr};

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (req_fire) begin
            state <= st_calc;
          end
        end
        st_calc: begin
          if (count == '0) begin
            state <= st_done;
          end
        end
        st_done: begin
          if (resp_fire) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_fire) begin
      dvd   <= mag_a;
      dvsr  <= mag_b;
      rem   <= '0;
      count <= (muldiv_pkg::count_width)'(muldiv_pkg::iter_count - 1);
      q_neg <= operands.a[31] ^ operands.b[31];
      r_neg <= operands.a[31];
      dvz   <= (operands.b == '0);
    end else if (state == st_calc) begin
      // restore on a negative trial, keep the difference otherwise
      if (!trial[32]) begin
        rem <= trial[31:0];
      end else begin
        rem <= rem_shift[31:0];
      end
      dvd   <= {dvd[30:0], !trial[32]};
      count <= count - 1'b1;
    end
  end

  // quotient truncates toward zero, remainder follows the dividend
  // a zero divisor forces an all ones quotient
  always_comb begin
    if (dvz) begin
      result.divres.quotient = '1;
    end else begin
      result.divres.quotient = q_neg ? (~dvd + 32'd1) : dvd;
    end
    result.divres.remainder = r_neg ? (~rem + 32'd1) : rem;
  end

  // response held until taken
  assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(result));

endmodule

`default_nettype wire

/* source/muldiv_csr.sv */
/* AXI4-Lite register block of the accelerator
   operand and command registers, unit dispatch and result capture */

`timescale 1ns/1ps
`default_nettype none

module muldiv_csr (
  input  logic                        clk,
  input  logic                        reset,
  input  muldiv_regs_pkg::axil_req_t  axil_req,
  output muldiv_regs_pkg::axil_rsp_t  axil_rsp,
  output muldiv_pkg::operands_t       operands,
  output logic                        mul_req_val,
  output logic                        div_req_val,
  input  logic                        mul_req_rdy,
  input  logic                        div_req_rdy,
  input  logic                        mul_resp_val,
  input  logic                        div_resp_val,
  input  muldiv_pkg::muldiv_result_u  mul_result,
  input  muldiv_pkg::muldiv_result_u  div_result,
  output logic                        mul_resp_rdy,
  output logic                        div_resp_rdy
);

  muldiv_pkg::operands_t      operands_q;
  muldiv_pkg::muldiv_result_u result_q;
  muldiv_pkg::muldiv_op_e     op_q;
  logic busy_q;
  logic done_q;
  logic start_q;
  logic req_val_q;

  logic        bvalid_q;
  logic [1:0]  bresp_q;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic [1:0]  rresp_q;

  logic        wr_fire;
  logic        rd_fire;
  logic        req_fire;
  logic        resp_fire;
  logic [1:0]  wr_resp;
  logic [31:0] rd_data;
  logic [1:0]  rd_resp;

  // address and data taken together, only with no write response pending
  assign wr_fire  = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
  assign rd_fire  = axil_req.arvalid && !rvalid_q;

  assign operands     = operands_q;
  assign mul_req_val  = req_val_q && (op_q == muldiv_pkg::op_mul);
  assign div_req_val  = req_val_q && (op_q == muldiv_pkg::op_div);
  assign mul_resp_rdy = busy_q && (op_q == muldiv_pkg::op_mul);
  assign div_resp_rdy = busy_q && (op_q == muldiv_pkg::op_div);
  assign req_fire     = (mul_req_val && mul_req_rdy) || (div_req_val && div_req_rdy);
  assign resp_fire    = (mul_resp_val && mul_resp_rdy) || (div_resp_val && div_resp_rdy);

  // ------------------------------------------------------------
  // command and status
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      op_q      <= muldiv_pkg::op_mul;
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      start_q   <= 1'b0;
      req_val_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      // start while busy is dropped silently
      if (wr_fire && axil_req.awaddr == muldiv_regs_pkg::reg_ctrl &&
          axil_req.wdata[muldiv_regs_pkg::ctrl_start_bit] && !busy_q) begin
        op_q    <= muldiv_pkg::muldiv_op_e'(axil_req.wdata[muldiv_regs_pkg::ctrl_op_bit]);
        busy_q  <= 1'b1;
        done_q  <= 1'b0;
        start_q <= 1'b1;
      end
      // request stays up until the selected unit takes it
      if (start_q) begin
        req_val_q <= 1'b1;
      end else if (req_fire) begin
        req_val_q <= 1'b0;
      end
      if (resp_fire) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  // operand and result storage
  always_ff @(posedge clk) begin
    if (wr_fire && axil_req.awaddr == muldiv_regs_pkg::reg_opa) begin
      operands_q.a <= axil_req.wdata;
    end
    if (wr_fire && axil_req.awaddr == muldiv_regs_pkg::reg_opb) begin
      operands_q.b <= axil_req.wdata;
    end
    if (resp_fire) begin
      result_q <= (op_q == muldiv_pkg::op_div) ? div_result : mul_result;
    end
  end

  // ------------------------------------------------------------
  // address decode
  // ------------------------------------------------------------

  // status and result registers are read only
  always_comb begin
    case (axil_req.awaddr)
      muldiv_regs_pkg::reg_opa,
      muldiv_regs_pkg::reg_opb,
      muldiv_regs_pkg::reg_ctrl: wr_resp = muldiv_regs_pkg::resp_okay;
      default:                   wr_resp = muldiv_regs_pkg::resp_slverr;
    endcase
  end

  always_comb begin
    rd_data = '0;
    rd_resp = muldiv_regs_pkg::resp_okay;
    case (axil_req.araddr)
      muldiv_regs_pkg::reg_opa:    rd_data = operands_q.a;
      muldiv_regs_pkg::reg_opb:    rd_data = operands_q.b;
      muldiv_regs_pkg::reg_ctrl:   rd_data[muldiv_regs_pkg::ctrl_op_bit] = op_q;
      muldiv_regs_pkg::reg_status: begin
        rd_data[muldiv_regs_pkg::stat_busy_bit] = busy_q;
        rd_data[muldiv_regs_pkg::stat_done_bit] = done_q;
      end
      muldiv_regs_pkg::reg_res_lo: rd_data = result_q.product[31:0];
      muldiv_regs_pkg::reg_res_hi: rd_data = result_q.product[63:32];
      default:                     rd_resp = muldiv_regs_pkg::resp_slverr;
    endcase
  end

  // ------------------------------------------------------------
  // response channels
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp_q <= wr_resp;
    end
    if (rd_fire) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  always_comb begin
    axil_rsp.awready = wr_fire;
    axil_rsp.wready  = wr_fire;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.bresp   = bresp_q;
    axil_rsp.arready = rd_fire;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
  end

  // the other unit is idle whenever one is asked
  assert property (@(posedge clk) disable iff (reset)
    mul_req_val |-> div_req_rdy);

  assert property (@(posedge clk) disable iff (reset)
    div_req_val |-> mul_req_rdy);

  // write response held until the master takes it
  assert property (@(posedge clk) disable iff (reset)
    bvalid_q && !axil_req.bready |=> bvalid_q && $stable(bresp_q));

endmodule

`default_nettype wire

/* source/muldiv_top.sv */
/* top level of the multiply/divide accelerator
   register block beside the multiplier and divider units */

`timescale 1ns/1ps
`default_nettype none

module muldiv_top (
  input  logic                       clk,
  input  logic                       reset,
  input  muldiv_regs_pkg::axil_req_t axil_req,
  output muldiv_regs_pkg::axil_rsp_t axil_rsp
);

  // operand bus shared by both units
  muldiv_pkg::operands_t      operands;
  muldiv_pkg::muldiv_result_u mul_result;
  muldiv_pkg::muldiv_result_u div_result;
  logic mul_req_val;
  logic mul_req_rdy;
  logic mul_resp_val;
  logic mul_resp_rdy;
  logic div_req_val;
  logic div_req_rdy;
  logic div_resp_val;
  logic div_resp_rdy;

  muldiv_csr i_csr (
    .clk          (clk),
    .reset        (reset),
    .axil_req     (axil_req),
    .axil_rsp     (axil_rsp),
    .operands     (operands),
    .mul_req_val  (mul_req_val),
    .div_req_val  (div_req_val),
    .mul_req_rdy  (mul_req_rdy),
    .div_req_rdy  (div_req_rdy),
    .mul_resp_val (mul_resp_val),
    .div_resp_val (div_resp_val),
    .mul_result   (mul_result),
    .div_result   (div_result),
    .mul_resp_rdy (mul_resp_rdy),
    .div_resp_rdy (div_resp_rdy)
  );

  int_mul_iterative i_mul (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .operands (operands),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .result   (mul_result)
  );

  int_div_iterative i_div (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .operands (operands),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy),
    .result   (div_result)
  );

endmodule

`default_nettype wire

/* testbench/muldiv_checker.sv */
/* result checker of the multiply/divide testbench
   compares AXI read data, write responses and ready handshakes, counts tests */

`timescale 1ns/1ps
`default_nettype none

module muldiv_checker (
  input  logic                       clk,
  input  logic                       reset,
  input  muldiv_regs_pkg::axil_req_t axil_req,
  input  muldiv_regs_pkg::axil_rsp_t axil_rsp,
  input  logic                       chk_en,
  input  logic [31:0]                exp_rdata,
  input  logic [1:0]                 exp_rresp,
  input  logic                       bchk_en,
  input  logic [1:0]                 exp_bresp,
  input  logic                       test_end,
  input  int                         test_num,
  input  logic [1:0]                 test_kind,
  input  logic                       report,
  output int                         mismatches,
  output int                         tests_failed,
  output int                         tests_run
);

  // set by any mismatch inside the current test
  logic  test_bad;
  string label;
  logic  exp_wr_rdy;
  logic  exp_rd_rdy;

  // ------------------------------------------------------------
  // compare on the handshake edge
  // ------------------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      mismatches   = 0;
      tests_failed = 0;
      tests_run    = 0;
      test_bad     = 1'b0;
    end else begin
      // ready pulses only when valid is up and no response is pending
      exp_wr_rdy = axil_req.awvalid && axil_req.wvalid && !axil_rsp.bvalid;
      exp_rd_rdy = axil_req.arvalid && !axil_rsp.rvalid;
      if (axil_rsp.awready !== exp_wr_rdy) begin
        $display("error at %0t ns: awready got %b expected %b",
                 $time, axil_rsp.awready, exp_wr_rdy);
        mismatches = mismatches + 1;
        test_bad   = 1'b1;
      end
      if (axil_rsp.wready !== exp_wr_rdy) begin
        $display("error at %0t ns: wready got %b expected %b",
                 $time, axil_rsp.wready, exp_wr_rdy);
        mismatches = mismatches + 1;
        test_bad   = 1'b1;
      end
      if (axil_rsp.arready !== exp_rd_rdy) begin
        $display("error at %0t ns: arready got %b expected %b",
                 $time, axil_rsp.arready, exp_rd_rdy);
        mismatches = mismatches + 1;
        test_bad   = 1'b1;
      end
      // read beat taken this edge
      if (chk_en && axil_rsp.rvalid && axil_req.rready) begin
        if (axil_rsp.rdata !== exp_rdata) begin
          $display("error at %0t ns: rdata got %h expected %h",
                   $time, axil_rsp.rdata, exp_rdata);
          mismatches = mismatches + 1;
          test_bad   = 1'b1;
        end
        if (axil_rsp.rresp !== exp_rresp) begin
          $display("error at %0t ns: rresp got %0d expected %0d",
                   $time, axil_rsp.rresp, exp_rresp);
          mismatches = mismatches + 1;
          test_bad   = 1'b1;
        end
      end
      // write response taken this edge
      if (bchk_en && axil_rsp.bvalid && axil_req.bready) begin
        if (axil_rsp.bresp !== exp_bresp) begin
          $display("error at %0t ns: bresp got %0d expected %0d",
                   $time, axil_rsp.bresp, exp_bresp);
          mismatches = mismatches + 1;
          test_bad   = 1'b1;
        end
      end
      // one line per finished test
      if (test_end) begin
        case (test_kind)
          2'd0:    label = "mul";
          2'd1:    label = "div";
          default: label = "reg";
        endcase
        tests_run = tests_run + 1;
        if (test_bad) begin
          tests_failed = tests_failed + 1;
          $display("test %0d %s failed", test_num, label);
        end else begin
          $display("test %0d %s passed", test_num, label);
        end
        test_bad = 1'b0;
      end
      if (report) begin
        $display("summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
                 tests_run, tests_run - tests_failed, tests_failed, mismatches);
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/muldiv_tb.sv */
/* testbench of the multiply/divide accelerator
   clock and reset, AXI4-Lite tasks, vector replay, random and register tests */

`timescale 1ns/1ps
`default_nettype none

module muldiv_tb;

  localparam int max_vectors  = 64;
  localparam int random_tests = 40;

  logic clk = 1'b0;
  logic reset;

  muldiv_regs_pkg::axil_req_t axil_req;
  muldiv_regs_pkg::axil_rsp_t axil_rsp;

  // checker controls
  logic        chk_en;
  logic [31:0] exp_rdata;
  logic [1:0]  exp_rresp;
  logic        bchk_en;
  logic [1:0]  exp_bresp;
  logic        test_end;
  int          test_num;
  logic [1:0]  test_kind;
  logic        report;
  int          mismatches;
  int          tests_failed;
  int          tests_run;

  // directed vectors from the data file
  logic        vec_op [0:max_vectors-1];
  logic [31:0] vec_a  [0:max_vectors-1];
  logic [31:0] vec_b  [0:max_vectors-1];
  logic [31:0] vec_hi [0:max_vectors-1];
  logic [31:0] vec_lo [0:max_vectors-1];
  int          n_vec;

  logic [8*128-1:0] line;
  logic [31:0] f_op;
  logic [31:0] f_a;
  logic [31:0] f_b;
  logic [31:0] f_hi;
  logic [31:0] f_lo;
  int          fd;

  logic [31:0] rd_data;
  logic [1:0]  rd_resp;
  logic        r_op;
  logic [31:0] r_a;
  logic [31:0] r_b;
  muldiv_pkg::muldiv_result_u expect_res;
  int unsigned seed_draw;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  muldiv_top i_muldiv_top (
    .clk      (clk),
    .reset    (reset),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  muldiv_checker i_checker (
    .clk          (clk),
    .reset        (reset),
    .axil_req     (axil_req),
    .axil_rsp     (axil_rsp),
    .chk_en       (chk_en),
    .exp_rdata    (exp_rdata),
    .exp_rresp    (exp_rresp),
    .bchk_en      (bchk_en),
    .exp_bresp    (exp_bresp),
    .test_end     (test_end),
    .test_num     (test_num),
    .test_kind    (test_kind),
    .report       (report),
    .mismatches   (mismatches),
    .tests_failed (tests_failed),
    .tests_run    (tests_run)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // hang guard, limit set once the vectors are counted
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: the DUT gave no result within %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // bus tasks, called and returning on a falling edge
  // ------------------------------------------------------------

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hf;
    axil_req.bready  = 1'b1;
    // bvalid shows that address and data were taken
    do @(negedge clk); while (!axil_rsp.bvalid);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    @(negedge clk);
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    axil_req.rready  = 1'b1;
    do @(negedge clk); while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    axil_req.arvalid = 1'b0;
    @(negedge clk);
    axil_req.rready = 1'b0;
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] data,
                             input logic [1:0] resp);
    chk_en    = 1'b1;
    exp_rdata = data;
    exp_rresp = resp;
    axil_read(addr, rd_data, rd_resp);
    chk_en = 1'b0;
  endtask

  task automatic write_expect(input logic [7:0] addr, input logic [31:0] data,
                              input logic [1:0] resp);
    bchk_en   = 1'b1;
    exp_bresp = resp;
    axil_write(addr, data);
    bchk_en = 1'b0;
  endtask

  task automatic close_test(input logic [1:0] kind);
    test_num  = test_num + 1;
    test_kind = kind;
    test_end  = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  task automatic poll_until_done();
    do begin
      axil_read(muldiv_regs_pkg::reg_status, rd_data, rd_resp);
    end while (!rd_data[muldiv_regs_pkg::stat_done_bit]);
  endtask

  task automatic start_op(input logic op);
    logic [31:0] ctrl;
    ctrl = '0;
    ctrl[muldiv_regs_pkg::ctrl_start_bit] = 1'b1;
    ctrl[muldiv_regs_pkg::ctrl_op_bit]    = op;
    write_expect(muldiv_regs_pkg::reg_ctrl, ctrl, muldiv_regs_pkg::resp_okay);
  endtask

  // operands in, start, wait for done, check both result words
  task automatic run_operation(input logic op, input logic [31:0] a, input logic [31:0] b,
                               input logic [31:0] exp_hi, input logic [31:0] exp_lo);
    axil_write(muldiv_regs_pkg::reg_opa, a);
    axil_write(muldiv_regs_pkg::reg_opb, b);
    start_op(op);
    poll_until_done();
    read_expect(muldiv_regs_pkg::reg_res_lo, exp_lo, muldiv_regs_pkg::resp_okay);
    read_expect(muldiv_regs_pkg::reg_res_hi, exp_hi, muldiv_regs_pkg::resp_okay);
    close_test(op ? 2'd1 : 2'd0);
  endtask

  // signed reference, quotient toward zero and remainder with the dividend sign
  function automatic muldiv_pkg::muldiv_result_u model_result(input logic op,
                                                              input logic [31:0] a,
                                                              input logic [31:0] b);
    muldiv_pkg::muldiv_result_u res;
    logic [63:0] wa;
    logic [63:0] wb;
    logic [63:0] ma;
    logic [63:0] mb;
    logic [63:0] q;
    logic [63:0] r;
    wa = {{32{a[31]}}, a};
    wb = {{32{b[31]}}, b};
    ma = a[31] ? -wa : wa;
    mb = b[31] ? -wb : wb;
    if (op == muldiv_pkg::op_mul) begin
      res.product = wa * wb;
    end else if (b == 32'd0) begin
      res.divres.quotient  = '1;
      res.divres.remainder = a;
    end else begin
      q = ma / mb;
      r = ma % mb;
      if (a[31] ^ b[31]) begin
        q = -q;
      end
      if (a[31]) begin
        r = -r;
      end
      res.divres.quotient  = q[31:0];
      res.divres.remainder = r[31:0];
    end
    return res;
  endfunction

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------

  initial begin
    seed_draw = $urandom(32'hc5e894b7);
    reset     = 1'b1;
    axil_req  = '0;
    chk_en    = 1'b0;
    exp_rdata = '0;
    exp_rresp = '0;
    bchk_en   = 1'b0;
    exp_bresp = '0;
    test_end  = 1'b0;
    test_num  = 0;
    test_kind = 2'd2;
    report    = 1'b0;
    n_vec     = 0;

    fd = $fopen("testbench/muldiv_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/muldiv_vectors.txt");
      $display("CHECKS FAILED");
      $finish;
    end else begin
      // header and blank lines do not scan as five fields
      while (!$feof(fd) && n_vec < max_vectors) begin
        if ($fgets(line, fd) != 0) begin
          if ($sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_hi, f_lo) == 5) begin
            vec_op[n_vec] = f_op[0];
            vec_a[n_vec]  = f_a;
            vec_b[n_vec]  = f_b;
            vec_hi[n_vec] = f_hi;
            vec_lo[n_vec] = f_lo;
            n_vec = n_vec + 1;
          end
        end
      end
      $fclose(fd);
      cycle_limit = (n_vec + random_tests) * 80;

      repeat (2) @(negedge clk);
      reset = 1'b0;

      // directed vectors
      for (int i = 0; i < n_vec; i++) begin
        run_operation(vec_op[i], vec_a[i], vec_b[i], vec_hi[i], vec_lo[i]);
      end

      // random ops, magnitudes of b spread by a random shift
      for (int i = 0; i < random_tests; i++) begin
        r_op = $urandom & 1;
        r_a  = $urandom;
        r_b  = $urandom >> ($urandom % 32);
        if ($urandom & 1) begin
          r_b = -r_b;
        end
        expect_res = model_result(r_op, r_a, r_b);
        run_operation(r_op, r_a, r_b, expect_res.product[63:32], expect_res.product[31:0]);
      end

      // operand registers read back
      axil_write(muldiv_regs_pkg::reg_opa, 32'ha5a55a5a);
      axil_write(muldiv_regs_pkg::reg_opb, 32'h0f0f00f0);
      read_expect(muldiv_regs_pkg::reg_opa, 32'ha5a55a5a, muldiv_regs_pkg::resp_okay);
      read_expect(muldiv_regs_pkg::reg_opb, 32'h0f0f00f0, muldiv_regs_pkg::resp_okay);
      close_test(2'd2);

      // unmapped offset
      read_expect(8'h18, 32'd0, muldiv_regs_pkg::resp_slverr);
      close_test(2'd2);

      // status is read only
      write_expect(muldiv_regs_pkg::reg_status, 32'h3, muldiv_regs_pkg::resp_slverr);
      close_test(2'd2);

      // busy then done, a divide start while busy is dropped
      axil_write(muldiv_regs_pkg::reg_opa, 32'h00001234);
      axil_write(muldiv_regs_pkg::reg_opb, 32'hffff0002);
      start_op(muldiv_pkg::op_mul);
      read_expect(muldiv_regs_pkg::reg_status, 32'h1, muldiv_regs_pkg::resp_okay);
      start_op(muldiv_pkg::op_div);
      read_expect(muldiv_regs_pkg::reg_status, 32'h1, muldiv_regs_pkg::resp_okay);
      poll_until_done();
      read_expect(muldiv_regs_pkg::reg_status, 32'h2, muldiv_regs_pkg::resp_okay);
      expect_res = model_result(muldiv_pkg::op_mul, 32'h00001234, 32'hffff0002);
      read_expect(muldiv_regs_pkg::reg_res_lo, expect_res.product[31:0],
                  muldiv_regs_pkg::resp_okay);
      read_expect(muldiv_regs_pkg::reg_res_hi, expect_res.product[63:32],
                  muldiv_regs_pkg::resp_okay);
      close_test(2'd2);

      report = 1'b1;
      @(negedge clk);
      report = 1'b0;
      if (n_vec > 0 && mismatches == 0 && tests_failed == 0 && tests_run == test_num) begin
        $display("ALL CHECKS PASSED");
      end else begin
        if (n_vec == 0) begin
          $display("no vectors were read from the data file");
        end
        if (tests_run != test_num) begin
          $display("checker saw %0d test ends out of %0d", tests_run, test_num);
        end
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* testbench/muldiv_vectors.txt */
// columns op a b exp_hi exp_lo in hex
// op 0 multiplies and op 1 divides, exp_hi holds the remainder of a divide
0 00000007 00000006 00000000 0000002A
0 FFFFFFFD 00000005 FFFFFFFF FFFFFFF1
0 FFFFFFF9 FFFFFFF8 00000000 00000038
0 00000000 12345678 00000000 00000000
0 80000000 80000000 40000000 00000000
0 80000000 00000001 FFFFFFFF 80000000
0 FFFFFFFF FFFFFFFF 00000000 00000001
0 7FFFFFFF 7FFFFFFF 3FFFFFFF 00000001
0 80000000 FFFFFFFF 00000000 80000000
0 00010000 FFFF0000 FFFFFFFF 00000000
1 00000064 00000007 00000002 0000000E
1 FFFFFF9C 00000007 FFFFFFFE FFFFFFF2
1 00000064 FFFFFFF9 00000002 FFFFFFF2
1 FFFFFF9C FFFFFFF9 FFFFFFFE 0000000E
1 00000005 0000000A 00000005 00000000
1 12345678 00000000 12345678 FFFFFFFF
1 80000000 FFFFFFFF 00000000 80000000
1 80000000 00000000 80000000 FFFFFFFF
1 80000000 00000002 00000000 C0000000
1 7FFFFFFF 00010000 0000FFFF 00007FFF

/* verilog.f */
source/muldiv_pkg.sv
source/muldiv_regs_pkg.sv
source/int_mul_iterative.sv
source/int_div_iterative.sv
source/muldiv_csr.sv
source/muldiv_top.sv
testbench/muldiv_checker.sv
testbench/muldiv_tb.sv

/* Bender.yml */
package:
  name: muldiv

sources:
  - files:
      - source/muldiv_pkg.sv
      - source/muldiv_regs_pkg.sv
      - source/int_mul_iterative.sv
      - source/int_div_iterative.sv
      - source/muldiv_csr.sv
      - source/muldiv_top.sv
  - target: test
    files:
      - testbench/muldiv_checker.sv
      - testbench/muldiv_tb.sv
